/* tb.f */
tx_buffer_pkg.sv
tx_word_ram.sv
tx_bank.sv
internet_checksum.sv
tx_buffer.sv
tb_tx_buffer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and look for the pass line in the log
set -u
cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --timing -j 0 --top-module tb_tx_buffer -f tb.f -o tb_sim; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "PASS: all tests" "$LOG"; then
  echo "Simulation passed"
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1

/* tb_tx_buffer.sv */
`timescale 1ns/1ps
/* Table-driven testbench for the transmit packet buffer. Fills packets from an
   LFSR, checks checksum, length, ping-pong dispatch, error, clear and full */

module tb_tx_buffer;

  localparam int AW      = 4;
  localparam int NUM_PKT = 6;
  // Table columns
  localparam int C_WORDS = 0;
  localparam int C_LEN   = 1;
  localparam int C_START = 2;
  localparam int C_BYTES = 3;
  localparam int C_INIT  = 4;
  localparam int C_HOLD  = 5;
  // words, length bytes (0 keeps count), sum start word, sum bytes, sum reset, hold
  localparam int PACKETS [NUM_PKT][6] = '{
    '{ 4,  0, 0,  32, 'h0000, 0},
    '{ 5, 29, 1,  21, 'h1234, 0},
    '{ 3, 24, 0,   0, 'habcd, 1},
    '{ 6, 45, 2,  27, 'hffff, 0},
    '{16,  0, 0, 127, 'h0f0f, 0},
    '{ 2,  9, 0,   9, 'h0000, 0}
  };

  logic i_clk, i_areset, i_write_en, i_sum_reset, i_sum_en, i_update_length;
  logic i_parser_done, i_parser_clear, i_fifo_rd_en, i_packet_read;
  logic [63:0] i_write_data;
  logic [15:0] i_sum_reset_value;
  logic [AW-1:0] i_sum_start_word;
  logic [AW+2:0] i_sum_bytes, i_length_bytes;
  logic [15:0] o_sum;
  logic o_sum_done, o_busy, o_parser_current_empty, o_parser_memory_full, o_error;
  logic o_packet_available, o_fifo_empty;
  logic [63:0] o_fifo_rd_data;
  logic [3:0] o_bytes_last_word;

  // Expected packet contents, two slots for ping-pong
  logic [63:0] pkt_words [2][2**AW];
  int          pkt_count [2];
  int          pkt_last [2];
  logic [31:0] lfsr_q = 32'h917ae68c;
  int          slot;
  bit          held;

  tx_buffer #(.ADDR_WIDTH(AW)) DUT (.*);

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  // ------------------------------------------------------------
  // Checking and data helpers
  // ------------------------------------------------------------

  task automatic stop_with_failure();
    $display("FAIL: see errors above");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
      stop_with_failure();
    end
  endtask

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One step per bit taken
  task automatic next_word(output logic [63:0] w);
    for (int b = 0; b < 64; b++) begin
      w      = {w[62:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // Ones-complement sum, bytes past the count zeroed, byte 0 most significant
  function automatic logic [15:0] ref_checksum(input int s, input logic [15:0] init,
                                               input int start, input int nbytes);
    logic [31:0] acc;
    logic [63:0] w;
    int          left;
    acc  = {16'h0000, init};
    left = nbytes;
    for (int k = start; left > 0; k++) begin
      w = pkt_words[s][k];
      for (int b = 0; b < 8; b++) begin
        if (b >= left) w[63-8*b -: 8] = 8'h00;
      end
      for (int f = 0; f < 4; f++) begin
        acc = acc + w[63-16*f -: 16];
        acc = (acc & 32'hffff) + (acc >> 16);
      end
      left = left - 8;
    end
    return acc[15:0];
  endfunction

  // ------------------------------------------------------------
  // Parser and dispatch sequences
  // ------------------------------------------------------------

  // Full is expected once the write that reaches the top is presented
  task automatic write_words(input int s, input int n);
    logic [63:0] w;
    for (int k = 0; k < n; k++) begin
      next_word(w);
      pkt_words[s][k] = w;
      @(posedge i_clk);
      i_write_en   <= 1'b1;
      i_write_data <= w;
      @(negedge i_clk);
      check_value("o_parser_memory_full", 64'(o_parser_memory_full), 64'(k >= 2**AW - 2));
    end
    @(posedge i_clk);
    i_write_en <= 1'b0;
  endtask

  task automatic fill_packet(input int i, input int s);
    int len;
    len = PACKETS[i][C_LEN];
    write_words(s, PACKETS[i][C_WORDS]);
    @(posedge i_clk);
    i_sum_reset       <= 1'b1;
    i_sum_reset_value <= 16'(PACKETS[i][C_INIT]);
    @(posedge i_clk);
    i_sum_reset      <= 1'b0;
    i_sum_en         <= 1'b1;
    i_sum_start_word <= AW'(PACKETS[i][C_START]);
    i_sum_bytes      <= (AW+3)'(PACKETS[i][C_BYTES]);
    @(posedge i_clk);
    i_sum_en <= 1'b0;
    @(negedge i_clk);
    // Engine stays busy until the done pulse
    while (!o_sum_done) begin
      check_value("o_busy", 64'(o_busy), 64'(1));
      @(negedge i_clk);
    end
    check_value("o_sum", 64'(o_sum), 64'(ref_checksum(s, 16'(PACKETS[i][C_INIT]),
                PACKETS[i][C_START], PACKETS[i][C_BYTES])));
    check_value("o_busy", 64'(o_busy), 64'(0));
    if (len != 0) begin
      @(posedge i_clk);
      i_update_length <= 1'b1;
      i_length_bytes  <= (AW+3)'(len);
      @(posedge i_clk);
      i_update_length <= 1'b0;
    end
    @(posedge i_clk);
    i_parser_done <= 1'b1;
    @(posedge i_clk);
    i_parser_done <= 1'b0;
    // ceil(len/8) words, len mod 8 in the last word, 8 when it divides
    pkt_count[s] = (len == 0) ? PACKETS[i][C_WORDS] : (len + 7) / 8;
    pkt_last[s]  = (len % 8 == 0) ? 8 : len % 8;
  endtask

  task automatic dispatch_packet(input int s);
    @(negedge i_clk);
    while (!o_packet_available) @(negedge i_clk);
    check_value("o_bytes_last_word", 64'(o_bytes_last_word), 64'(pkt_last[s]));
    for (int k = 0; k < pkt_count[s]; k++) begin
      check_value("o_fifo_empty", 64'(o_fifo_empty), 64'(0));
      check_value("o_fifo_rd_data", o_fifo_rd_data, pkt_words[s][k]);
      @(posedge i_clk);
      i_fifo_rd_en <= 1'b1;
      @(posedge i_clk);
      i_fifo_rd_en <= 1'b0;
      @(negedge i_clk);
    end
    check_value("o_fifo_empty", 64'(o_fifo_empty), 64'(1));
    @(posedge i_clk);
    i_packet_read <= 1'b1;
    @(posedge i_clk);
    i_packet_read <= 1'b0;
    @(negedge i_clk);
    check_value("o_packet_available", 64'(o_packet_available), 64'(0));
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------

  initial begin
    i_areset <= 1'b1;
    i_write_en <= 1'b0;
    i_write_data <= '0;
    i_sum_reset <= 1'b0;
    i_sum_reset_value <= '0;
    i_sum_en <= 1'b0;
    i_sum_start_word <= '0;
    i_sum_bytes <= '0;
    i_update_length <= 1'b0;
    i_length_bytes <= '0;
    i_parser_done <= 1'b0;
    i_parser_clear <= 1'b0;
    i_fifo_rd_en <= 1'b0;
    i_packet_read <= 1'b0;
    repeat (8) @(posedge i_clk);
    i_areset <= 1'b0;
    @(negedge i_clk);
    check_value("o_sum", 64'(o_sum), 64'(0));
    check_value("o_sum_done", 64'(o_sum_done), 64'(0));
    check_value("o_busy", 64'(o_busy), 64'(0));
    check_value("o_error", 64'(o_error), 64'(0));
    check_value("o_packet_available", 64'(o_packet_available), 64'(0));
    check_value("o_parser_current_empty", 64'(o_parser_current_empty), 64'(1));
    slot = 0;
    held = 1'b0;
    for (int i = 0; i < NUM_PKT; i++) begin
      fill_packet(i, slot);
      if (held) begin
        // Finished bank waits behind the undispatched one
        repeat (3) begin
          @(negedge i_clk);
          check_value("o_parser_memory_full", 64'(o_parser_memory_full), 64'(1));
        end
        dispatch_packet(slot ^ 1);
        @(negedge i_clk);
        while (!o_packet_available) @(negedge i_clk);
        check_value("o_parser_memory_full", 64'(o_parser_memory_full), 64'(0));
        check_value("o_parser_current_empty", 64'(o_parser_current_empty), 64'(1));
        held = 1'b0;
        dispatch_packet(slot);
      end else if (PACKETS[i][C_HOLD] != 0) begin
        held = 1'b1;
        @(negedge i_clk);
        while (!o_parser_current_empty) @(negedge i_clk);
      end else begin
        dispatch_packet(slot);
      end
      slot = slot ^ 1;
    end
    // Done on an empty parser bank
    check_value("o_parser_current_empty", 64'(o_parser_current_empty), 64'(1));
    @(posedge i_clk);
    i_parser_done <= 1'b1;
    @(posedge i_clk);
    i_parser_done <= 1'b0;
    @(negedge i_clk);
    check_value("o_error", 64'(o_error), 64'(1));
    @(negedge i_clk);
    check_value("o_error", 64'(o_error), 64'(0));
    // Partial packet dropped by clear
    write_words(slot, 3);
    @(posedge i_clk);
    i_parser_clear <= 1'b1;
    @(posedge i_clk);
    i_parser_clear <= 1'b0;
    repeat (4) begin
      @(negedge i_clk);
      check_value("o_parser_current_empty", 64'(o_parser_current_empty), 64'(1));
      check_value("o_packet_available", 64'(o_packet_available), 64'(0));
    end
    $display("PASS: all tests");
    $finish;
  end

  // Watchdog scaled by the words in the table
  initial begin
    int total;
    total = 0;
    for (int i = 0; i < NUM_PKT; i++) total += PACKETS[i][C_WORDS];
    repeat (8 * total + 60 * NUM_PKT + 300) @(posedge i_clk);
    $display("Watchdog expired before the test sequence finished");
    stop_with_failure();
  end

endmodule

/* tx_buffer.sv */
`timescale 1ns/1ps
/* Double-buffered transmit packet buffer. The parser fills one bank while
   dispatch drains the other; banks swap when a packet is done */

module tx_buffer #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                            i_clk,
  input  logic                            i_areset,
  // Parser side
  input  logic                            i_write_en,
  input  tx_buffer_pkg::tx_word_t         i_write_data,
  input  logic                            i_sum_reset,
  input  logic [tx_buffer_pkg::SUM_W-1:0] i_sum_reset_value,
  input  logic                            i_sum_en,
  input  logic [ADDR_WIDTH-1:0]           i_sum_start_word,
  input  logic [ADDR_WIDTH+2:0]           i_sum_bytes,
  input  logic                            i_update_length,
  input  logic [ADDR_WIDTH+2:0]           i_length_bytes,
  input  logic                            i_parser_done,
  input  logic                            i_parser_clear,
  output logic [tx_buffer_pkg::SUM_W-1:0] o_sum,
  output logic                            o_sum_done,
  output logic                            o_busy,
  output logic                            o_parser_current_empty,
  output logic                            o_parser_memory_full,
  output logic                            o_error,
  // Dispatch side
  output logic                            o_packet_available,
  output logic                            o_fifo_empty,
  output tx_buffer_pkg::tx_word_t         o_fifo_rd_data,
  output logic [3:0]                      o_bytes_last_word,
  input  logic                            i_fifo_rd_en,
  input  logic                            i_packet_read
);

  // Index of the bank the parser writes
  logic                       current_q;
  logic [1:0]                 par_sel;
  logic [1:0]                 disp_sel;
  tx_buffer_pkg::bank_state_t bank_state [2];
  tx_buffer_pkg::tx_word_t    bank_rd_data [2];
  logic [1:0]                 bank_full;
  logic [1:0]                 bank_fifo_empty;
  logic [3:0]                 bank_last [2];
  tx_buffer_pkg::bank_state_t parser_state;
  tx_buffer_pkg::bank_state_t fifo_state;
  logic                       sum_go;
  logic                       swap;
  logic                       bad_cmd_q;
  logic                       sum_rd_en;
  logic                       sum_last;
  logic [ADDR_WIDTH-1:0]      sum_rd_addr;

  // ----------------------------------------------------------
  // Bank ownership and swap
  // ----------------------------------------------------------

  assign par_sel      = {current_q, ~current_q};
  assign disp_sel     = ~par_sel;
  assign parser_state = bank_state[current_q];
  assign fifo_state   = bank_state[~current_q];
  // Checksum only on a bank that holds data
  assign sum_go = i_sum_en && parser_state == tx_buffer_pkg::BANK_HAS_DATA;
  assign swap   = parser_state == tx_buffer_pkg::BANK_FIFO_OUT &&
                  fifo_state == tx_buffer_pkg::BANK_EMPTY;

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      current_q <= 1'b0;
      bad_cmd_q <= 1'b0;
    end else begin
      if (swap) begin
        current_q <= ~current_q;
      end
      // Commands that need a packet but find the bank empty
      bad_cmd_q <= parser_state == tx_buffer_pkg::BANK_EMPTY &&
                   (i_sum_en || i_update_length || i_parser_done);
    end
  end

  tx_bank #(.ADDR_WIDTH(ADDR_WIDTH)) bank0 (
    .i_clk(i_clk), .i_areset(i_areset),
    .i_write_en(i_write_en & par_sel[0]), .i_write_data(i_write_data),
    .i_sum_start(sum_go & par_sel[0]), .i_sum_bytes_zero(i_sum_bytes == '0),
    .i_sum_rd_en(sum_rd_en & par_sel[0]), .i_sum_rd_addr(sum_rd_addr),
    .i_sum_last(sum_last & par_sel[0]),
    .i_update_length(i_update_length & par_sel[0]), .i_length_bytes(i_length_bytes),
    .i_done(i_parser_done & par_sel[0]), .i_clear(i_parser_clear & par_sel[0]),
    .i_swap(swap),
    .i_fifo_rd_en(i_fifo_rd_en & disp_sel[0]), .i_packet_read(i_packet_read & disp_sel[0]),
    .o_state(bank_state[0]), .o_rd_data(bank_rd_data[0]), .o_full(bank_full[0]),
    .o_fifo_empty(bank_fifo_empty[0]), .o_bytes_last_word(bank_last[0])
  );

  tx_bank #(.ADDR_WIDTH(ADDR_WIDTH)) bank1 (
    .i_clk(i_clk), .i_areset(i_areset),
    .i_write_en(i_write_en & par_sel[1]), .i_write_data(i_write_data),
    .i_sum_start(sum_go & par_sel[1]), .i_sum_bytes_zero(i_sum_bytes == '0),
    .i_sum_rd_en(sum_rd_en & par_sel[1]), .i_sum_rd_addr(sum_rd_addr),
    .i_sum_last(sum_last & par_sel[1]),
    .i_update_length(i_update_length & par_sel[1]), .i_length_bytes(i_length_bytes),
    .i_done(i_parser_done & par_sel[1]), .i_clear(i_parser_clear & par_sel[1]),
    .i_swap(swap),
    .i_fifo_rd_en(i_fifo_rd_en & disp_sel[1]), .i_packet_read(i_packet_read & disp_sel[1]),
    .o_state(bank_state[1]), .o_rd_data(bank_rd_data[1]), .o_full(bank_full[1]),
    .o_fifo_empty(bank_fifo_empty[1]), .o_bytes_last_word(bank_last[1])
  );

  // Checksum reads the parser bank
  internet_checksum #(.ADDR_WIDTH(ADDR_WIDTH)) u_checksum (
    .i_clk(i_clk), .i_areset(i_areset),
    .i_sum_reset(i_sum_reset), .i_sum_reset_value(i_sum_reset_value),
    .i_sum_en(sum_go), .i_start_word(i_sum_start_word), .i_bytes(i_sum_bytes),
    .i_rd_data(bank_rd_data[current_q]),
    .o_rd_en(sum_rd_en), .o_rd_addr(sum_rd_addr), .o_last(sum_last),
    .o_sum(o_sum), .o_sum_done(o_sum_done), .o_busy(o_busy)
  );

  // ----------------------------------------------------------
  // Flags and dispatch outputs
  // ----------------------------------------------------------

  assign o_error                = bad_cmd_q;
  assign o_parser_current_empty = parser_state == tx_buffer_pkg::BANK_EMPTY;
  assign o_parser_memory_full   = bank_full[current_q];
  assign o_packet_available     = fifo_state == tx_buffer_pkg::BANK_FIFO_OUT;
  assign o_fifo_empty           = bank_fifo_empty[~current_q];
  assign o_fifo_rd_data         = bank_rd_data[~current_q];
  assign o_bytes_last_word      = bank_last[~current_q];

endmodule

/* internet_checksum.sv */
`timescale 1ns/1ps
/* Ones-complement Internet checksum over a word-aligned byte range of the
   parser bank. Reads one word per cycle and adds it one cycle later */

module internet_checksum #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                            i_clk,
  input  logic                            i_areset,
  input  logic                            i_sum_reset,
  input  logic [tx_buffer_pkg::SUM_W-1:0] i_sum_reset_value,
  input  logic                            i_sum_en,
  input  logic [ADDR_WIDTH-1:0]           i_start_word,
  input  logic [ADDR_WIDTH+2:0]           i_bytes,
  input  tx_buffer_pkg::tx_word_t         i_rd_data,
  output logic                            o_rd_en,
  output logic [ADDR_WIDTH-1:0]           o_rd_addr,
  output logic                            o_last,
  output logic [tx_buffer_pkg::SUM_W-1:0] o_sum,
  output logic                            o_sum_done,
  output logic                            o_busy
);

  localparam int SW = tx_buffer_pkg::SUM_W;
  localparam logic [ADDR_WIDTH+2:0] WORD_BYTES = (ADDR_WIDTH+3)'(tx_buffer_pkg::BYTES_PER_WORD);

  logic                  run_q;
  logic [ADDR_WIDTH-1:0] addr_q;
  logic [ADDR_WIDTH+2:0] rem_q;
  logic                  add_valid_q;
  logic                  add_last_q;
  logic [3:0]            add_bytes_q;
  logic [SW-1:0]         sum_q;
  logic                  done_q;
  logic [3:0]            word_bytes;
  logic [SW-1:0]         sum_next;

  // Valid bytes in the word requested this cycle
  assign word_bytes = (rem_q > WORD_BYTES) ? 4'(tx_buffer_pkg::BYTES_PER_WORD) : rem_q[3:0];
  assign o_last     = run_q && (rem_q <= WORD_BYTES);

  // ----------------------------------------------------------
  // Masking and ones-complement add
  // ----------------------------------------------------------

  always_comb begin
    tx_buffer_pkg::tx_word_t masked;
    logic [SW+2:0]           total;
    logic [SW:0]             fold;
    masked = i_rd_data;
    // Zero the bytes past the end of the range
    for (int i = 0; i < tx_buffer_pkg::BYTES_PER_WORD; i++) begin
      if (4'(i) >= add_bytes_q) begin
        masked.bytes[i] = 8'h00;
      end
    end
    total = {3'b000, sum_q} +
            {3'b000, masked.fields[0]} +
            {3'b000, masked.fields[1]} +
            {3'b000, masked.fields[2]} +
            {3'b000, masked.fields[3]};
    // Two folds bring any carry back into 16 bits
    fold     = {1'b0, total[SW-1:0]} + {{(SW-2){1'b0}}, total[SW+2:SW]};
    sum_next = fold[SW-1:0] + {{(SW-1){1'b0}}, fold[SW]};
  end

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      run_q       <= 1'b0;
      addr_q      <= '0;
      rem_q       <= '0;
      add_valid_q <= 1'b0;
      add_last_q  <= 1'b0;
      add_bytes_q <= 4'd0;
      sum_q       <= '0;
      done_q      <= 1'b0;
    end else begin
      done_q <= 1'b0;
      // Read stage
      if (i_sum_en && !run_q) begin
        addr_q <= i_start_word;
        rem_q  <= i_bytes;
        run_q  <= (i_bytes != '0);
        // Empty range finishes at once with the sum untouched
        done_q <= (i_bytes == '0);
      end else if (run_q) begin
        addr_q <= addr_q + ADDR_WIDTH'(1);
        rem_q  <= o_last ? '0 : rem_q - WORD_BYTES;
        run_q  <= !o_last;
      end
      // Add stage, lines up with the RAM output
      add_valid_q <= run_q;
      add_last_q  <= o_last;
      add_bytes_q <= word_bytes;
      if (i_sum_reset) begin
        sum_q <= i_sum_reset_value;
      end else if (add_valid_q) begin
        sum_q <= sum_next;
      end
      if (add_valid_q && add_last_q) begin
        done_q <= 1'b1;
      end
    end
  end

  assign o_rd_en    = run_q;
  assign o_rd_addr  = addr_q;
  assign o_sum      = sum_q;
  assign o_sum_done = done_q;
  assign o_busy     = run_q || add_valid_q;

endmodule

/* tx_bank.sv */
`timescale 1ns/1ps
/* One bank of the ping-pong transmit buffer. Tracks the packet state, the
   shared write/dispatch pointer, the word count and the last-word bytes */

module tx_bank #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                       i_clk,
  input  logic                       i_areset,
  input  logic                       i_write_en,
  input  tx_buffer_pkg::tx_word_t    i_write_data,
  input  logic                       i_sum_start,
  input  logic                       i_sum_bytes_zero,
  input  logic                       i_sum_rd_en,
  input  logic [ADDR_WIDTH-1:0]      i_sum_rd_addr,
  input  logic                       i_sum_last,
  input  logic                       i_update_length,
  input  logic [ADDR_WIDTH+2:0]      i_length_bytes,
  input  logic                       i_done,
  input  logic                       i_clear,
  input  logic                       i_swap,
  input  logic                       i_fifo_rd_en,
  input  logic                       i_packet_read,
  output tx_buffer_pkg::bank_state_t o_state,
  output tx_buffer_pkg::tx_word_t    o_rd_data,
  output logic                       o_full,
  output logic                       o_fifo_empty,
  output logic [3:0]                 o_bytes_last_word
);

  // Pointer carries one extra bit so a completely filled bank is visible
  localparam logic [ADDR_WIDTH:0] TOP_ADDR  = {1'b0, {ADDR_WIDTH{1'b1}}};
  localparam logic [ADDR_WIDTH:0] NEAR_TOP  = {1'b0, {(ADDR_WIDTH-1){1'b1}}, 1'b0};
  localparam logic [3:0]          FULL_WORD = 4'(tx_buffer_pkg::BYTES_PER_WORD);

  tx_buffer_pkg::bank_state_t state_q;
  logic [ADDR_WIDTH:0]        ptr_q;
  logic [ADDR_WIDTH:0]        ptr_d;
  logic [ADDR_WIDTH:0]        count_q;
  logic [3:0]                 last_q;
  logic                       ram_we;
  logic                       fifo_adv;
  logic [ADDR_WIDTH-1:0]      ram_rd_addr;
  logic [ADDR_WIDTH:0]        len_words;
  logic [3:0]                 len_last;

  // ----------------------------------------------------------
  // Pointer and memory addressing
  // ----------------------------------------------------------

  // Appends only while the parser owns the bank and space is left
  assign ram_we = i_write_en && !ptr_q[ADDR_WIDTH] &&
                  (state_q == tx_buffer_pkg::BANK_EMPTY ||
                   state_q == tx_buffer_pkg::BANK_HAS_DATA);
  // Dispatch stops advancing at the word count
  assign fifo_adv = i_fifo_rd_en && !o_fifo_empty &&
                    state_q == tx_buffer_pkg::BANK_FIFO_OUT;

  always_comb begin
    ptr_d = ptr_q;
    if (i_clear || i_swap || i_packet_read) begin
      ptr_d = '0;
    end else if (ram_we || fifo_adv) begin
      ptr_d = ptr_q + (ADDR_WIDTH+1)'(1);
    end
  end

  // Read the next pointer so the RAM output tracks the current one
  assign ram_rd_addr = (state_q == tx_buffer_pkg::BANK_CHECKSUM && i_sum_rd_en) ?
                       i_sum_rd_addr : ptr_d[ADDR_WIDTH-1:0];

  // Length update: ceil(bytes/8) words, remainder bytes in the last
  assign len_words = {1'b0, i_length_bytes[ADDR_WIDTH+2:3]} +
                     {{ADDR_WIDTH{1'b0}}, |i_length_bytes[2:0]};

  always_comb begin
    if (i_length_bytes == '0) begin
      len_last = 4'd0;
    end else if (i_length_bytes[2:0] == 3'd0) begin
      len_last = FULL_WORD;
    end else begin
      len_last = {1'b0, i_length_bytes[2:0]};
    end
  end

  // ----------------------------------------------------------
  // Bank FSM
  // ----------------------------------------------------------

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state_q <= tx_buffer_pkg::BANK_EMPTY;
      ptr_q   <= '0;
      count_q <= '0;
      last_q  <= 4'd0;
    end else begin
      ptr_q <= ptr_d;
      if (i_clear) begin
        state_q <= tx_buffer_pkg::BANK_EMPTY;
        count_q <= '0;
        last_q  <= 4'd0;
      end else begin
        case (state_q)
          tx_buffer_pkg::BANK_EMPTY: begin
            if (ram_we) begin
              state_q <= tx_buffer_pkg::BANK_HAS_DATA;
              count_q <= ptr_d;
              last_q  <= FULL_WORD;
            end
          end
          tx_buffer_pkg::BANK_HAS_DATA: begin
            if (ram_we) begin
              count_q <= ptr_d;
              last_q  <= FULL_WORD;
            end
            // Explicit length wins over the appended word count
            if (i_update_length) begin
              count_q <= len_words;
              last_q  <= len_last;
            end
            if (i_done) begin
              state_q <= tx_buffer_pkg::BANK_FIFO_OUT;
            end else if (i_sum_start && !i_sum_bytes_zero) begin
              state_q <= tx_buffer_pkg::BANK_CHECKSUM;
            end
          end
          // Checksum engine flags its final read
          tx_buffer_pkg::BANK_CHECKSUM: begin
            if (i_sum_last) begin
              state_q <= tx_buffer_pkg::BANK_HAS_DATA;
            end
          end
          default: begin
            if (i_packet_read) begin
              state_q <= tx_buffer_pkg::BANK_EMPTY;
              count_q <= '0;
              last_q  <= 4'd0;
            end
          end
        endcase
      end
    end
  end

  tx_word_ram #(.ADDR_WIDTH(ADDR_WIDTH)) u_ram (
    .i_clk     (i_clk),
    .i_wr_en   (ram_we),
    .i_wr_addr (ptr_q[ADDR_WIDTH-1:0]),
    .i_wr_data (i_write_data),
    .i_rd_addr (ram_rd_addr),
    .o_rd_data (o_rd_data)
  );

  assign o_state           = state_q;
  assign o_fifo_empty      = (ptr_q == count_q);
  assign o_bytes_last_word = last_q;
  // Full once finished, at the top, or about to reach it
  assign o_full = (state_q > tx_buffer_pkg::BANK_HAS_DATA) || (ptr_q >= TOP_ADDR) ||
                  (ptr_q == NEAR_TOP && i_write_en);

endmodule

/* tx_word_ram.sv */
`timescale 1ns/1ps
/* Word memory for one buffer bank. One synchronous write port and one
   read port whose address is sampled on every clock edge */

module tx_word_ram #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                    i_clk,
  input  logic                    i_wr_en,
  input  logic [ADDR_WIDTH-1:0]   i_wr_addr,
  input  tx_buffer_pkg::tx_word_t i_wr_data,
  input  logic [ADDR_WIDTH-1:0]   i_rd_addr,
  output tx_buffer_pkg::tx_word_t o_rd_data
);

  // Storage, maps onto a block RAM
  tx_buffer_pkg::tx_word_t mem [2**ADDR_WIDTH];

  // Write port
  always_ff @(posedge i_clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_data;
    end
  end

  // Registered read, one cycle from address to data
  always_ff @(posedge i_clk) begin
    o_rd_data <= mem[i_rd_addr];
  end

endmodule

/* tx_buffer_pkg.sv */
/* Shared word geometry, bank states and the two-way view of a data word
   for the transmit packet buffer; modules refer to it by scoped names */

package tx_buffer_pkg;

  // ----------------------------------------------------------
  // Word geometry
  // ----------------------------------------------------------

  // Bytes carried by one memory word
  localparam int BYTES_PER_WORD = 8;
  // Data word width in bits
  localparam int WORD_W = 64;
  // Internet checksum width
  localparam int SUM_W = 16;
  // Number of 16-bit fields summed per word
  localparam int FIELDS_PER_WORD = WORD_W / SUM_W;

  // ----------------------------------------------------------
  // Bank life cycle
  // ----------------------------------------------------------

  typedef enum logic [1:0] {
    BANK_EMPTY    = 2'd0,
    BANK_HAS_DATA = 2'd1,
    BANK_CHECKSUM = 2'd2,
    BANK_FIFO_OUT = 2'd3
  } bank_state_t;

  // One memory word, seen as bytes for masking or as fields for summing
  // Index 0 is the most significant byte or field in both views
  typedef union packed {
    logic [0:BYTES_PER_WORD-1][7:0]        bytes;
    logic [0:FIELDS_PER_WORD-1][SUM_W-1:0] fields;
  } tx_word_t;

endpackage
